//--- list.f
+incdir+common
common/riscv_isa_pkg.sv
common/csr_pipe_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
csrfile/csrfile.sv
source/csr_pipeline_top.sv
verification/csr_pipeline_properties.sv
verification/csr_pipeline_tb.sv

//--- run.sh
#!/bin/sh
# build and run the csr pipeline testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module csr_pipeline_tb -f list.f &&
./obj_dir/Vcsr_pipeline_tb | tee /dev/stderr | grep -q "^Everything OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verification/csr_pipeline_tb.sv
`include "csr_cfg.svh"

module csr_pipeline_tb
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {
    kind_rd,
    kind_no_rd,
    kind_handler
  } check_kind_e;

  typedef struct {
    int          tid;
    word_t       instr;
    word_t       rs1;
    logic        trap;
    word_t       cause;
    check_kind_e kind;
    int          gap;
  } entry_t;

  typedef struct {
    int        tid;
    int        due;
    logic      handler;
    logic      last;
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } pending_t;

  localparam logic [2:0] f3_rw  = 3'b001;
  localparam logic [2:0] f3_rs  = 3'b010;
  localparam logic [2:0] f3_rc  = 3'b011;
  localparam logic [2:0] f3_rwi = 3'b101;
  localparam logic [2:0] f3_rsi = 3'b110;
  localparam logic [2:0] f3_rci = 3'b111;
  localparam csr_addr_t  addr_unknown = 12'h7c0;

  logic      clk_i;
  logic      rst_i;
  logic      instr_valid_i;
  word_t     instr_i;
  word_t     pc_i;
  word_t     rs1_data_i;
  logic      trap_valid_i;
  word_t     trap_mcause_i;
  logic      rd_we_o;
  reg_addr_t rd_addr_o;
  word_t     rd_data_o;
  word_t     trap_handler_addr_o;

  entry_t   table_q[$];
  pending_t pending_q[$];
  int       edge_n;
  int       cycle_count;
  int       cycle_limit;
  int       error_count;
  int       tests_passed;
  int       tests_failed;
  int       test_errors[int];

  // reference copy of the machine csrs
  word_t       ref_mtvec;
  word_t       ref_mscratch;
  word_t       ref_mepc;
  word_t       ref_mcause;
  word_t       ref_mtval;
  int unsigned strobes;

  csr_pipeline_top dut (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .instr_valid_i       (instr_valid_i),
    .instr_i             (instr_i),
    .pc_i                (pc_i),
    .rs1_data_i          (rs1_data_i),
    .trap_valid_i        (trap_valid_i),
    .trap_mcause_i       (trap_mcause_i),
    .rd_we_o             (rd_we_o),
    .rd_addr_o           (rd_addr_o),
    .rd_data_o           (rd_data_o),
    .trap_handler_addr_o (trap_handler_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t csr_instr(csr_addr_t a, logic [4:0] src, logic [2:0] f3,
                                      reg_addr_t rd);
    return {a, src, f3, rd, opcode_system};
  endfunction

  task automatic add_entry(int tid, word_t instr, word_t rs1, logic trap, word_t cause,
                           check_kind_e kind, int gap);
    entry_t e;
    e.tid   = tid;
    e.instr = instr;
    e.rs1   = rs1;
    e.trap  = trap;
    e.cause = cause;
    e.kind  = kind;
    e.gap   = gap;
    table_q.push_back(e);
  endtask

  function automatic word_t ref_read(csr_addr_t a);
    case (a)
      csr_addr_mtvec:     return ref_mtvec;
      csr_addr_mscratch:  return ref_mscratch;
      csr_addr_mepc:      return ref_mepc;
      csr_addr_mcause:    return ref_mcause;
      csr_addr_mtval:     return ref_mtval;
      // mcycle counts edges since reset release, low half only here
      csr_addr_mcycle:    return word_t'(edge_n);
      csr_addr_minstret:  return word_t'(strobes);
      default:            return '0;
    endcase
  endfunction

  task automatic ref_write(csr_addr_t a, word_t v);
    case (a)
      csr_addr_mtvec:    ref_mtvec = v & 32'hffff_fffc;
      csr_addr_mscratch: ref_mscratch = v;
      csr_addr_mepc:     ref_mepc = v;
      csr_addr_mcause:   ref_mcause = v;
      csr_addr_mtval:    ref_mtval = v;
      default: ;
    endcase
  endtask

  task automatic report_mismatch(int tid, string name, word_t got, word_t exp);
    $display("CHECK FAILED test %0d %s got %h expected %h", tid, name, got, exp);
    error_count++;
    test_errors[tid] = test_errors[tid] + 1;
  endtask

  task automatic next_edge();
    @(posedge clk_i);
    edge_n++;
  endtask

  task automatic drive_idle();
    instr_valid_i <= 1'b0;
    trap_valid_i  <= 1'b0;
  endtask

  // models one strobe and queues the checks it leads to
  task automatic apply_entry(entry_t e, int idx);
    pending_t  p;
    word_t     pc;
    word_t     old_value;
    word_t     new_value;
    word_t     operand;
    logic [2:0] f3;
    logic [4:0] src;
    csr_addr_t  a;
    logic       is_csr;
    pc        = word_t'(32'h1000 + 4 * idx);
    f3        = e.instr[14:12];
    src       = e.instr[19:15];
    a         = e.instr[31:20];
    is_csr    = (e.instr[6:0] == 7'b1110011) && (f3[1:0] != 2'b00);
    old_value = ref_read(a);
    operand   = f3[2] ? {27'b0, src} : e.rs1;
    case (f3[1:0])
      2'b01:   new_value = operand;
      2'b10:   new_value = old_value | operand;
      default: new_value = old_value & ~operand;
    endcase
    if (is_csr && !e.trap && ((f3[1:0] == 2'b01) || (src != 5'd0))) begin
      ref_write(a, new_value);
    end
    if (e.trap) begin
      ref_mepc   = pc;
      ref_mcause = e.cause;
    end
    strobes++;
    test_errors[e.tid] = 0;
    p.tid     = e.tid;
    p.due     = edge_n + 2;
    p.handler = 1'b0;
    p.last    = (e.kind != kind_handler);
    p.we      = (e.kind != kind_no_rd);
    p.addr    = e.instr[11:7];
    p.data    = old_value;
    pending_q.push_back(p);
    if (e.kind == kind_handler) begin
      p.due     = edge_n + e.gap;
      p.handler = 1'b1;
      p.last    = 1'b1;
      p.data    = ref_mtvec;
      pending_q.push_back(p);
    end
    instr_valid_i <= 1'b1;
    instr_i       <= e.instr;
    pc_i          <= pc;
    rs1_data_i    <= e.rs1;
    trap_valid_i  <= e.trap;
    trap_mcause_i <= e.cause;
  endtask

  // outputs are compared at the falling edge, away from the update
  task automatic check_due();
    pending_t p;
    @(negedge clk_i);
    while (pending_q.size() > 0 && pending_q[0].due == edge_n) begin
      p = pending_q.pop_front();
      if (p.handler) begin
        if (trap_handler_addr_o !== p.data) begin
          report_mismatch(p.tid, "trap_handler_addr_o", trap_handler_addr_o, p.data);
        end
      end else begin
        if (rd_we_o !== p.we) begin
          report_mismatch(p.tid, "rd_we_o", word_t'(rd_we_o), word_t'(p.we));
        end
        if (p.we && rd_addr_o !== p.addr) begin
          report_mismatch(p.tid, "rd_addr_o", word_t'(rd_addr_o), word_t'(p.addr));
        end
        if (p.we && rd_data_o !== p.data) begin
          report_mismatch(p.tid, "rd_data_o", rd_data_o, p.data);
        end
      end
      if (p.last) begin
        if (test_errors[p.tid] == 0) begin
          $display("test %0d passed", p.tid);
          tests_passed++;
        end else begin
          $display("test %0d failed with %0d errors", p.tid, test_errors[p.tid]);
          tests_failed++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // read-modify-write on mscratch, back to back
    add_entry(1, csr_instr(csr_addr_mscratch, 5'd1, f3_rw, 5'd5), 32'h1234_5678, 0, 0, kind_rd, 0);
    add_entry(2, csr_instr(csr_addr_mscratch, 5'd2, f3_rs, 5'd6), 32'h0000_ff00, 0, 0, kind_rd, 0);
    add_entry(3, csr_instr(csr_addr_mscratch, 5'd3, f3_rc, 5'd7), 32'h0000_0f00, 0, 0, kind_rd, 0);
    add_entry(4, csr_instr(csr_addr_mscratch, 5'd0, f3_rs, 5'd8), 32'hffff_ffff, 0, 0, kind_rd, 0);
    // immediate forms on mtval
    add_entry(5, csr_instr(csr_addr_mtval, 5'h15, f3_rwi, 5'd9), 32'h0, 0, 0, kind_rd, 1);
    add_entry(6, csr_instr(csr_addr_mtval, 5'h0a, f3_rsi, 5'd10), 32'h0, 0, 0, kind_rd, 0);
    add_entry(7, csr_instr(csr_addr_mtval, 5'h01, f3_rci, 5'd11), 32'h0, 0, 0, kind_rd, 2);
    add_entry(8, csr_instr(csr_addr_mtval, 5'h00, f3_rsi, 5'd12), 32'h0, 0, 0, kind_rd, 0);
    // rd x0, then a distance one read
    add_entry(9, csr_instr(csr_addr_mscratch, 5'd4, f3_rs, 5'd0), 32'hdead_beef, 0, 0,
              kind_no_rd, 0);
    add_entry(10, csr_instr(csr_addr_mscratch, 5'd0, f3_rs, 5'd13), 32'h0, 0, 0, kind_rd, 0);
    add_entry(11, csr_instr(csr_addr_mscratch, 5'd0, f3_rc, 5'd14), 32'hffff_ffff, 0, 0,
              kind_rd, 0);
    // distance two read through the write-through path
    add_entry(12, csr_instr(csr_addr_mtval, 5'd5, f3_rw, 5'd1), 32'h0000_a5a5, 0, 0, kind_rd, 1);
    add_entry(13, csr_instr(csr_addr_mtval, 5'd0, f3_rs, 5'd2), 32'h0, 0, 0, kind_rd, 3);
    // mtvec alignment and the handler address
    add_entry(14, csr_instr(csr_addr_mtvec, 5'd6, f3_rw, 5'd3), 32'h8000_0103, 0, 0,
              kind_handler, 5);
    add_entry(15, csr_instr(csr_addr_mtvec, 5'd0, f3_rs, 5'd4), 32'h0, 0, 0, kind_rd, 0);
    // trapped instruction, then reads of mepc and mcause
    add_entry(16, csr_instr(csr_addr_mscratch, 5'd7, f3_rw, 5'd5), 32'h0000_1111, 1,
              32'h0000_0002, kind_no_rd, 2);
    add_entry(17, csr_instr(csr_addr_mepc, 5'd0, f3_rs, 5'd6), 32'h0, 0, 0, kind_rd, 0);
    add_entry(18, csr_instr(csr_addr_mcause, 5'd0, f3_rs, 5'd7), 32'h0, 0, 0, kind_rd, 0);
    add_entry(19, csr_instr(csr_addr_mscratch, 5'd0, f3_rs, 5'd8), 32'h0, 0, 0, kind_rd, 0);
    // addi x9, x0, 1 retires without a csr access
    add_entry(20, 32'h0010_0493, 32'h0, 0, 0, kind_no_rd, 0);
    // counters ignore writes
    add_entry(21, csr_instr(csr_addr_mcycle, 5'd8, f3_rw, 5'd9), 32'h0000_ffff, 0, 0, kind_rd, 0);
    add_entry(22, csr_instr(csr_addr_mcycle, 5'd0, f3_rs, 5'd10), 32'h0, 0, 0, kind_rd, 3);
    add_entry(23, csr_instr(csr_addr_mcycleh, 5'd0, f3_rs, 5'd11), 32'h0, 0, 0, kind_rd, 0);
    add_entry(24, csr_instr(csr_addr_minstret, 5'd9, f3_rw, 5'd12), 32'h0000_0055, 0, 0,
              kind_rd, 0);
    add_entry(25, csr_instr(csr_addr_minstret, 5'd0, f3_rs, 5'd13), 32'h0, 0, 0, kind_rd, 1);
    add_entry(26, csr_instr(csr_addr_minstreth, 5'd0, f3_rs, 5'd14), 32'h0, 0, 0, kind_rd, 0);
    // unknown address reads zero and keeps nothing
    add_entry(27, csr_instr(addr_unknown, 5'd10, f3_rw, 5'd15), 32'h0000_1234, 0, 0, kind_rd, 0);
    add_entry(28, csr_instr(addr_unknown, 5'd0, f3_rs, 5'd16), 32'h0, 0, 0, kind_rd, 4);
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles with %0d checks still pending",
               cycle_count, pending_q.size());
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rs1_data_i    = '0;
    trap_valid_i  = 1'b0;
    trap_mcause_i = '0;
    cycle_count   = 0;
    error_count   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    strobes       = 0;
    ref_mtvec     = '0;
    ref_mscratch  = '0;
    ref_mepc      = '0;
    ref_mcause    = '0;
    ref_mtval     = '0;
    build_table();
    // reset, entries with their gaps, pipeline latency and a margin
    cycle_limit = 4 + 3 + 20;
    foreach (table_q[i]) begin
      cycle_limit = cycle_limit + 1 + table_q[i].gap;
    end

    repeat (4) @(posedge clk_i);
    rst_i  <= 1'b0;
    edge_n = 0;

    foreach (table_q[i]) begin
      next_edge();
      apply_entry(table_q[i], i);
      check_due();
      repeat (table_q[i].gap) begin
        next_edge();
        drive_idle();
        check_due();
      end
    end
    while (pending_q.size() > 0) begin
      next_edge();
      drive_idle();
      check_due();
    end

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verification/csr_pipeline_properties.sv
`include "csr_cfg.svh"

module csr_pipeline_properties
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input logic      rd_we_i,
  input reg_addr_t rd_addr_i,
  input word_t     trap_handler_addr_i
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // output rules of the csr pipeline
  ////////////////////////////////////////////////////////////////////////////

  // a reset edge leaves no rd write behind
  rd_we_low_in_reset: assert property (@(posedge clk_i) rst_i |=> !rd_we_i)
    else $error("rd_we_o high after a reset cycle");

  // x0 is never written
  no_rd_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_we_i |-> (rd_addr_i != '0))
    else $error("rd_we_o high for rd x0");

  // handler address stays word aligned
  handler_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    trap_handler_addr_i[1:0] == 2'b00)
    else $error("trap_handler_addr_o has nonzero low bits");

endmodule

bind csr_pipeline_top csr_pipeline_properties u_properties (
  .clk_i               (clk_i),
  .rst_i               (rst_i),
  .rd_we_i             (rd_we_o),
  .rd_addr_i           (rd_addr_o),
  .trap_handler_addr_i (trap_handler_addr_o)
);

//--- source/csr_pipeline_top.sv
`include "csr_cfg.svh"

module csr_pipeline_top
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     rs1_data_i,
  input  logic      trap_valid_i,
  input  word_t     trap_mcause_i,
  output logic      rd_we_o,
  output reg_addr_t rd_addr_o,
  output word_t     rd_data_o,
  output word_t     trap_handler_addr_o
);

  csr_addr_t csr_raddr;
  word_t     csr_rdata;
  id_ex_t    id_ex;
  ex_wb_t    ex_wb;

  csr_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .trap_valid_i  (trap_valid_i),
    .trap_mcause_i (trap_mcause_i),
    .csr_raddr_o   (csr_raddr),
    .csr_rdata_i   (csr_rdata),
    .id_ex_o       (id_ex)
  );

  // wb is the execute register itself, fed back for forwarding
  csr_execute u_execute (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .id_ex_i (id_ex),
    .wb_i    (ex_wb),
    .ex_wb_o (ex_wb)
  );

  csrfile u_csrfile (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .csr_raddr_i         (csr_raddr),
    .csr_rdata_o         (csr_rdata),
    .wb_i                (ex_wb),
    .ex_valid_i          (id_ex.valid),
    .trap_handler_addr_o (trap_handler_addr_o)
  );

  // rd result leaves from the write back stage
  assign rd_we_o   = ex_wb.rd_we;
  assign rd_addr_o = ex_wb.rd_addr;
  assign rd_data_o = ex_wb.rd_data;

endmodule

//--- csrfile/csrfile.sv
`include "csr_cfg.svh"

module csrfile
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  csr_addr_t csr_raddr_i,
  output word_t     csr_rdata_o,
  input  ex_wb_t    wb_i,
  input  logic      ex_valid_i,
  output word_t     trap_handler_addr_o
);

  word_t mtvec_q;
  word_t mscratch_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t mtval_q;
  logic [2*`CSR_XLEN-1:0] mcycle_q;
  logic [2*`CSR_XLEN-1:0] minstret_q;
  word_t trap_handler_q;

  logic  wb_wr;
  logic  wb_trap;
  word_t wr_value;
  logic  wr_hit;
  word_t minstret_lo;
  word_t stored;
  logic  rd_writable;

  //////////////////////////////////////////////////////////////////////////
  // write back side
  //////////////////////////////////////////////////////////////////////////

  assign wb_wr   = wb_i.valid && wb_i.csr_we;
  assign wb_trap = wb_i.valid && wb_i.trap_valid;

  // value as it lands in the register, mtvec keeps word alignment
  assign wr_value = (wb_i.csr_addr == csr_addr_mtvec) ?
                    (wb_i.csr_wdata & `CSR_MTVEC_MASK) : wb_i.csr_wdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      if (wb_wr) begin
        case (wb_i.csr_addr)
          csr_addr_mtvec:    mtvec_q    <= wr_value;
          csr_addr_mscratch: mscratch_q <= wr_value;
          csr_addr_mepc:     mepc_q     <= wr_value;
          csr_addr_mcause:   mcause_q   <= wr_value;
          csr_addr_mtval:    mtval_q    <= wr_value;
          // counters are read only here
          default: ;
        endcase
      end
      // trap report wins over a write in the same cycle
      if (wb_trap) begin
        mepc_q   <= wb_i.pc;
        mcause_q <= wb_i.trap_mcause;
      end
      mcycle_q <= mcycle_q + (2*`CSR_XLEN)'(1);
      if (wb_i.valid) begin
        minstret_q <= minstret_q + (2*`CSR_XLEN)'(1);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // read side, used by id
  //////////////////////////////////////////////////////////////////////////

  // instructions older than the reader that are still in flight
  assign minstret_lo = minstret_q[`CSR_XLEN-1:0] + word_t'(ex_valid_i) + word_t'(wb_i.valid);

  always_comb begin
    stored = '0;
    case (csr_raddr_i)
      csr_addr_mtvec:     stored = mtvec_q;
      csr_addr_mscratch:  stored = mscratch_q;
      csr_addr_mepc:      stored = mepc_q;
      csr_addr_mcause:    stored = mcause_q;
      csr_addr_mtval:     stored = mtval_q;
      csr_addr_mcycle:    stored = mcycle_q[`CSR_XLEN-1:0];
      csr_addr_mcycleh:   stored = mcycle_q[2*`CSR_XLEN-1:`CSR_XLEN];
      csr_addr_minstret:  stored = minstret_lo;
      csr_addr_minstreth: stored = minstret_q[2*`CSR_XLEN-1:`CSR_XLEN];
      default:            stored = '0;
    endcase
  end

  // write-through covers the instruction two ahead of the reader
  assign rd_writable = csr_is_writable(csr_raddr_i);
  assign wr_hit      = wb_wr && (wb_i.csr_addr == csr_raddr_i);

  assign csr_rdata_o = (wr_hit && rd_writable) ? wr_value : stored;

  //////////////////////////////////////////////////////////////////////////
  // trap target
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trap_handler_q <= '0;
    end else begin
      trap_handler_q <= mtvec_q;
    end
  end

  assign trap_handler_addr_o = trap_handler_q;

endmodule

//--- source/csr_execute.sv
`include "csr_cfg.svh"

module csr_execute
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  id_ex_t id_ex_i,
  input  ex_wb_t wb_i,
  output ex_wb_t ex_wb_o
);

  logic   fwd_hit;
  word_t  old_value;
  word_t  new_value;
  logic   csr_we;
  ex_wb_t ex_wb_d;
  ex_wb_t ex_wb_q;

  //////////////////////////////////////////////////////////////////////////
  // forwarding from write back
  //////////////////////////////////////////////////////////////////////////

  // the instruction one ahead has not committed yet when this one read in id
  assign fwd_hit = wb_i.valid && wb_i.csr_we && (wb_i.csr_addr == id_ex_i.csr_addr);

  assign old_value = fwd_hit ? wb_i.csr_wdata : id_ex_i.csr_rdata;

  always_comb begin
    case (id_ex_i.op)
      csr_op_rw: new_value = id_ex_i.operand;
      csr_op_rs: new_value = old_value | id_ex_i.operand;
      csr_op_rc: new_value = old_value & ~id_ex_i.operand;
      default:   new_value = old_value;
    endcase
  end

  // counters and unknown addresses take no write, so nothing is forwarded from them
  assign csr_we = id_ex_i.valid && id_ex_i.csr_we && !id_ex_i.trap_valid &&
                  csr_is_writable(id_ex_i.csr_addr);

  always_comb begin
    ex_wb_d             = '0;
    ex_wb_d.valid       = id_ex_i.valid;
    ex_wb_d.csr_addr    = id_ex_i.csr_addr;
    ex_wb_d.csr_we      = csr_we;
    // keep the forwarded value equal to what mtvec will hold
    ex_wb_d.csr_wdata   = (id_ex_i.csr_addr == csr_addr_mtvec) ?
                          (new_value & `CSR_MTVEC_MASK) : new_value;
    ex_wb_d.rd_addr     = id_ex_i.rd_addr;
    ex_wb_d.rd_we       = id_ex_i.valid && id_ex_i.rd_we && !id_ex_i.trap_valid;
    ex_wb_d.rd_data     = old_value;
    ex_wb_d.pc          = id_ex_i.pc;
    ex_wb_d.trap_valid  = id_ex_i.valid && id_ex_i.trap_valid;
    ex_wb_d.trap_mcause = id_ex_i.trap_mcause;
  end

  //////////////////////////////////////////////////////////////////////////
  // ex/wb stage register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    ex_wb_q <= ex_wb_d;
    if (rst_i) begin
      ex_wb_q.valid      <= 1'b0;
      ex_wb_q.csr_we     <= 1'b0;
      ex_wb_q.rd_we      <= 1'b0;
      ex_wb_q.trap_valid <= 1'b0;
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

//--- source/csr_decode.sv
`include "csr_cfg.svh"

module csr_decode
  import riscv_isa_pkg::*, csr_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     rs1_data_i,
  input  logic      trap_valid_i,
  input  word_t     trap_mcause_i,
  output csr_addr_t csr_raddr_o,
  input  word_t     csr_rdata_i,
  output id_ex_t    id_ex_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_addr_t  rd_field;
  reg_addr_t  rs1_field;
  logic       is_csr;
  csr_op_e    op;
  word_t      zimm;
  id_ex_t     id_ex_d;
  id_ex_t     id_ex_q;

  //////////////////////////////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////////////////////////////

  assign opcode    = instr_i[6:0];
  assign rd_field  = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign rs1_field = instr_i[19:15];

  // the csr is read during id, the file answers in the same cycle
  assign csr_raddr_o = instr_i[31:20];

  // zimm sits in the rs1 field
  assign zimm = {{(`CSR_XLEN - `CSR_REG_W){1'b0}}, rs1_field};

  // funct3 000 and 100 are ecall/ebreak/xret and reserved
  assign is_csr = (opcode == opcode_system) && (funct3[1:0] != 2'b00);

  always_comb begin
    op = csr_op_none;
    if (instr_valid_i && is_csr) begin
      case (funct3[1:0])
        2'b01:   op = csr_op_rw;
        2'b10:   op = csr_op_rs;
        2'b11:   op = csr_op_rc;
        default: op = csr_op_none;
      endcase
    end
  end

  always_comb begin
    id_ex_d             = '0;
    id_ex_d.valid       = instr_valid_i;
    id_ex_d.op          = op;
    id_ex_d.csr_addr    = instr_i[31:20];
    id_ex_d.rd_addr     = rd_field;
    id_ex_d.rd_we       = (op != csr_op_none) && (rd_field != '0);
    // set/clear with x0 or zimm 0 only read
    id_ex_d.csr_we      = (op == csr_op_rw) ||
                          ((op != csr_op_none) && (rs1_field != '0));
    id_ex_d.operand     = funct3[2] ? zimm : rs1_data_i;
    id_ex_d.csr_rdata   = csr_rdata_i;
    id_ex_d.pc          = pc_i;
    id_ex_d.trap_valid  = instr_valid_i && trap_valid_i;
    id_ex_d.trap_mcause = trap_mcause_i;
  end

  // id/ex stage register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- common/csr_pipe_pkg.sv
`include "csr_cfg.svh"

package csr_pipe_pkg;

  import riscv_isa_pkg::*;

  typedef logic [`CSR_XLEN-1:0] word_t;
  typedef logic [`CSR_REG_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////////////////////////////

  // decode to execute
  typedef struct packed {
    logic      valid;
    csr_op_e   op;
    csr_addr_t csr_addr;
    reg_addr_t rd_addr;
    // rd is not x0 and op is not none
    logic      rd_we;
    // rw always, rs/rc only with a nonzero rs1 field or zimm
    logic      csr_we;
    // rs1 data or the zero-extended zimm
    word_t     operand;
    // csr value read in id, may be stale by one instruction
    word_t     csr_rdata;
    word_t     pc;
    logic      trap_valid;
    word_t     trap_mcause;
  } id_ex_t;

  // execute to write back
  typedef struct packed {
    logic      valid;
    csr_addr_t csr_addr;
    logic      csr_we;
    word_t     csr_wdata;
    reg_addr_t rd_addr;
    logic      rd_we;
    // old csr value, returned on rd
    word_t     rd_data;
    word_t     pc;
    logic      trap_valid;
    word_t     trap_mcause;
  } ex_wb_t;

endpackage

//--- common/riscv_isa_pkg.sv
`include "csr_cfg.svh"

package riscv_isa_pkg;

  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  //////////////////////////////////////////////////////////////////////////
  // machine-mode csr addresses
  //////////////////////////////////////////////////////////////////////////

  localparam csr_addr_t csr_addr_mtvec     = 12'h305;
  localparam csr_addr_t csr_addr_mscratch  = 12'h340;
  localparam csr_addr_t csr_addr_mepc      = 12'h341;
  localparam csr_addr_t csr_addr_mcause    = 12'h342;
  localparam csr_addr_t csr_addr_mtval     = 12'h343;
  // counters, read only in this unit
  localparam csr_addr_t csr_addr_mcycle    = 12'hb00;
  localparam csr_addr_t csr_addr_mcycleh   = 12'hb80;
  localparam csr_addr_t csr_addr_minstret  = 12'hb02;
  localparam csr_addr_t csr_addr_minstreth = 12'hb82;

  // encoding follows funct3[1:0] of the csr instructions
  typedef enum logic [1:0] {
    csr_op_none = 2'b00,
    csr_op_rw   = 2'b01,
    csr_op_rs   = 2'b10,
    csr_op_rc   = 2'b11
  } csr_op_e;

  localparam logic [6:0] opcode_system = 7'b1110011;

  // the registers a csr instruction may change
  function automatic logic csr_is_writable(csr_addr_t addr);
    case (addr)
      csr_addr_mtvec, csr_addr_mscratch, csr_addr_mepc,
      csr_addr_mcause, csr_addr_mtval: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

//--- common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// fixed sizes of the rv32 machine-mode csr unit
////////////////////////////////////////////////////////////////////////////

// data word width
`define CSR_XLEN 32

// csr address field width, instr[31:20]
`define CSR_ADDR_W 12

// register index width, also the zimm width
`define CSR_REG_W 5

// mtvec is word aligned, the low two bits read as zero
`define CSR_MTVEC_MASK 32'hffff_fffc

`endif
